//--- build.sh
#!/bin/sh
# compile with Verilator, run, and grade the run from its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module move_gen_tb \
   -o move_gen_sim > build.log 2>&1 \
   || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/move_gen_sim > sim.log 2>&1 ; cat sim.log
grep -q -x -F '*** PASSED ***' sim.log && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

//--- design/check_detect.sv
`include "chess_consts.svh"

module check_detect
(
   input  logic                clk,
   input  logic                reset,
   input  logic                board_req,
   output logic                board_ack,
   input  chess_pkg::board_t   board_in,
   input  logic                white_to_move_in,
   input  chess_pkg::castle_t  castle_mask_in,
   input  chess_pkg::ep_col_t  en_passant_col_in,
   input  logic                gen_done,
   output logic                gen_start,
   output logic                store_clear,
   output logic                in_check,
   output chess_pkg::board_t   pos_board,
   output logic                pos_white_to_move,
   output chess_pkg::castle_t  pos_castle_mask,
   output chess_pkg::ep_col_t  pos_en_passant_col
);

   typedef enum logic [2:0] {S_IDLE, S_SCAN, S_RAY, S_GEN, S_WAIT, S_ACK} state_t;

   state_t             state;
   logic [5:0]         sq;
   logic [2:0]         ray_row;
   logic [2:0]         ray_col;
   chess_pkg::dir_t    dir;
   chess_pkg::piece_t  sq_piece;
   chess_pkg::piece_t  hit_piece;
   chess_pkg::piece_t  mover_king;
   logic [6:0]         nxt;
   logic               enemy_slider;

   assign mover_king = {~pos_white_to_move, `PIECE_KING};
   assign sq_piece = chess_pkg::sq_at(pos_board, sq[5:3], sq[2:0]);
   assign enemy_slider = sq_piece[`BLACK_BIT] == pos_white_to_move &&
                         (sq_piece[2:0] == `PIECE_ROOK || sq_piece[2:0] == `PIECE_QUEN);
   assign nxt = chess_pkg::ray_step(ray_row, ray_col, dir);
   assign hit_piece = chess_pkg::sq_at(pos_board, nxt[5:3], nxt[2:0]);

   always_ff @(posedge clk)
   begin
      gen_start <= 1'b0;
      store_clear <= 1'b0;
      if (reset)
      begin
         state <= S_IDLE;
         board_ack <= 1'b0;
         in_check <= 1'b0;
      end
      else
         case (state)
            S_IDLE:
               if (board_req)
               begin
                  in_check <= 1'b0;
                  sq <= '0;
                  state <= S_SCAN;
               end
            S_SCAN:
               if (enemy_slider)
               begin
                  ray_row <= sq[5:3];
                  ray_col <= sq[2:0];
                  dir <= chess_pkg::DIR_LEFT;
                  state <= S_RAY;
               end
               else if (sq == 6'd63)
                  state <= S_GEN;
               else
                  sq <= sq + 6'd1;
            S_RAY:
               if (nxt[6] && hit_piece == `EMPTY_POSN)
               begin
                  ray_row <= nxt[5:3];   // open square, keep walking
                  ray_col <= nxt[2:0];
               end
               else
               begin
                  if (nxt[6] && hit_piece == mover_king)
                     in_check <= 1'b1;
                  ray_row <= sq[5:3];
                  ray_col <= sq[2:0];
                  if (dir != chess_pkg::DIR_DOWN)
                     dir <= chess_pkg::dir_t'(dir + 2'd1);
                  else if (sq == 6'd63)
                     state <= S_GEN;
                  else
                  begin
                     sq <= sq + 6'd1;
                     state <= S_SCAN;
                  end
               end
            S_GEN:
            begin
               gen_start <= 1'b1;
               state <= S_WAIT;
            end
            S_WAIT:
               if (gen_done)
               begin
                  board_ack <= 1'b1;
                  state <= S_ACK;
               end
            S_ACK:
               if (!board_req)   // requester done reading back
               begin
                  board_ack <= 1'b0;
                  store_clear <= 1'b1;
                  state <= S_IDLE;
               end
            default: state <= S_IDLE;
         endcase
   end

   always_ff @(posedge clk)
      if (state == S_IDLE && board_req)
      begin
         pos_board <= board_in;
         pos_white_to_move <= white_to_move_in;
         pos_castle_mask <= castle_mask_in;
         pos_en_passant_col <= en_passant_col_in;
      end

   a_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
      $rose(board_ack) |-> board_req);

endmodule

//--- design/chess_consts.svh
`ifndef CHESS_CONSTS_SVH
`define CHESS_CONSTS_SVH

// square encoding, colour in the top bit
`define PIECE_BITS 4
`define BLACK_BIT 3
`define EMPTY_POSN 4'd0

// piece kinds, low three bits of a square
`define PIECE_PAWN 3'd1
`define PIECE_KNIT 3'd2
`define PIECE_BISH 3'd3
`define PIECE_ROOK 3'd4
`define PIECE_QUEN 3'd5
`define PIECE_KING 3'd6

`define BOARD_BITS (`PIECE_BITS * 64)
`define CASTLE_BITS 4
`define EP_BITS 4
`define ADDR_BITS 6

`define CASTLE_WHITE_SHORT 0
`define CASTLE_WHITE_LONG 1
`define CASTLE_BLACK_SHORT 2
`define CASTLE_BLACK_LONG 3

`define EN_PASSANT_INVALID 4'd8
`define MAX_POSITIONS 64

`endif

//--- design/chess_pkg.sv
`include "chess_consts.svh"

package chess_pkg;

   typedef logic [`PIECE_BITS-1:0] piece_t;
   typedef logic [`BOARD_BITS-1:0] board_t;   // row 0 is white's back rank
   typedef logic [`CASTLE_BITS-1:0] castle_t;
   typedef logic [`EP_BITS-1:0] ep_col_t;
   typedef logic [`ADDR_BITS-1:0] move_addr_t;

   // up means rising row
   typedef enum logic [1:0] {DIR_LEFT, DIR_RIGHT, DIR_UP, DIR_DOWN} dir_t;

   function automatic piece_t sq_at(board_t b, logic [2:0] r, logic [2:0] c);
      return b[{r, c, 2'b00} +: `PIECE_BITS];
   endfunction

   // {on board, row, col} one step along d
   function automatic logic [6:0] ray_step(logic [2:0] r, logic [2:0] c, dir_t d);
      logic [6:0] res;
      res = {1'b0, r, c};
      case (d)
         DIR_LEFT:  if (c != 3'd0) res = {1'b1, r, c - 3'd1};
         DIR_RIGHT: if (c != 3'd7) res = {1'b1, r, c + 3'd1};
         DIR_UP:    if (r != 3'd7) res = {1'b1, r + 3'd1, c};
         default:   if (r != 3'd0) res = {1'b1, r - 3'd1, c};
      endcase
      return res;
   endfunction

endpackage

//--- design/move_gen_top.sv
module move_gen_top
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   board_req,
   output logic                   board_ack,
   input  chess_pkg::board_t      board_in,
   input  logic                   white_to_move_in,
   input  chess_pkg::castle_t     castle_mask_in,
   input  chess_pkg::ep_col_t     en_passant_col_in,
   output logic                   in_check,
   input  chess_pkg::move_addr_t  move_index,
   output chess_pkg::move_addr_t  move_count,
   output chess_pkg::board_t      board_out,
   output logic                   white_to_move_out,
   output chess_pkg::castle_t     castle_mask_out,
   output chess_pkg::ep_col_t     en_passant_col_out
);

   logic                gen_start;
   logic                gen_done;
   logic                store_clear;
   logic                wr_en;
   chess_pkg::board_t   pos_board;
   logic                pos_white_to_move;
   chess_pkg::castle_t  pos_castle_mask;
   chess_pkg::ep_col_t  pos_en_passant_col;
   chess_pkg::board_t   wr_board;
   logic                wr_white_to_move;
   chess_pkg::castle_t  wr_castle_mask;
   chess_pkg::ep_col_t  wr_en_passant_col;

   check_detect u_check_detect
   (
      .clk                (clk),
      .reset              (reset),
      .board_req          (board_req),
      .board_ack          (board_ack),
      .board_in           (board_in),
      .white_to_move_in   (white_to_move_in),
      .castle_mask_in     (castle_mask_in),
      .en_passant_col_in  (en_passant_col_in),
      .gen_done           (gen_done),
      .gen_start          (gen_start),
      .store_clear        (store_clear),
      .in_check           (in_check),
      .pos_board          (pos_board),
      .pos_white_to_move  (pos_white_to_move),
      .pos_castle_mask    (pos_castle_mask),
      .pos_en_passant_col (pos_en_passant_col)
   );

   slide_moves u_slide_moves
   (
      .clk                (clk),
      .reset              (reset),
      .gen_start          (gen_start),
      .pos_board          (pos_board),
      .pos_white_to_move  (pos_white_to_move),
      .pos_castle_mask    (pos_castle_mask),
      .pos_en_passant_col (pos_en_passant_col),
      .wr_en              (wr_en),
      .wr_board           (wr_board),
      .wr_white_to_move   (wr_white_to_move),
      .wr_castle_mask     (wr_castle_mask),
      .wr_en_passant_col  (wr_en_passant_col),
      .gen_done           (gen_done)
   );

   move_store u_move_store
   (
      .clk                (clk),
      .reset              (reset),
      .store_clear        (store_clear),
      .wr_en              (wr_en),
      .wr_board           (wr_board),
      .wr_white_to_move   (wr_white_to_move),
      .wr_castle_mask     (wr_castle_mask),
      .wr_en_passant_col  (wr_en_passant_col),
      .move_index         (move_index),
      .move_count         (move_count),
      .board_out          (board_out),
      .white_to_move_out  (white_to_move_out),
      .castle_mask_out    (castle_mask_out),
      .en_passant_col_out (en_passant_col_out)
   );

endmodule

//--- design/move_store.sv
`include "chess_consts.svh"

module move_store
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   store_clear,
   input  logic                   wr_en,
   input  chess_pkg::board_t      wr_board,
   input  logic                   wr_white_to_move,
   input  chess_pkg::castle_t     wr_castle_mask,
   input  chess_pkg::ep_col_t     wr_en_passant_col,
   input  chess_pkg::move_addr_t  move_index,
   output chess_pkg::move_addr_t  move_count,
   output chess_pkg::board_t      board_out,
   output logic                   white_to_move_out,
   output chess_pkg::castle_t     castle_mask_out,
   output chess_pkg::ep_col_t     en_passant_col_out
);

   localparam int RAM_WIDTH = `BOARD_BITS + 1 + `CASTLE_BITS + `EP_BITS;
   localparam chess_pkg::move_addr_t LAST_ADDR = chess_pkg::move_addr_t'(`MAX_POSITIONS - 1);

   logic [RAM_WIDTH-1:0] ram [`MAX_POSITIONS];
   logic [RAM_WIDTH-1:0] rd_data;

   always_ff @(posedge clk)
   begin
      if (wr_en)
         ram[move_count] <= {wr_en_passant_col, wr_castle_mask, wr_white_to_move, wr_board};
      rd_data <= ram[move_index];
   end

   // append pointer, holds at the last slot
   always_ff @(posedge clk)
      if (reset)
         move_count <= '0;
      else if (store_clear)
         move_count <= '0;
      else if (wr_en && move_count != LAST_ADDR)
         move_count <= move_count + 1'b1;

   assign {en_passant_col_out, castle_mask_out, white_to_move_out, board_out} = rd_data;

   a_no_overflow: assert property (@(posedge clk) disable iff (reset)
      wr_en |-> move_count != LAST_ADDR);

endmodule

//--- design/slide_moves.sv
`include "chess_consts.svh"

module slide_moves
(
   input  logic                clk,
   input  logic                reset,
   input  logic                gen_start,
   input  chess_pkg::board_t   pos_board,
   input  logic                pos_white_to_move,
   input  chess_pkg::castle_t  pos_castle_mask,
   input  chess_pkg::ep_col_t  pos_en_passant_col,
   output logic                wr_en,
   output chess_pkg::board_t   wr_board,
   output logic                wr_white_to_move,
   output chess_pkg::castle_t  wr_castle_mask,
   output chess_pkg::ep_col_t  wr_en_passant_col,
   output logic                gen_done
);

   typedef enum logic [2:0] {S_IDLE, S_SQUARE, S_STEP, S_ADV, S_NEXT, S_DONE} state_t;

   state_t              state;
   logic [5:0]          sq;        // source square, row major
   logic [2:0]          cur_row;   // target square
   logic [2:0]          cur_col;
   chess_pkg::dir_t     dir;
   chess_pkg::piece_t   src_piece;
   chess_pkg::piece_t   cur_piece;
   logic                mover_black;
   logic                mover_slider;
   logic [3:0]          first_ok;
   logic [3:0]          later_ok;
   logic [5:0]          first_rc [4];
   logic [6:0]          nxt;
   logic                cont_ok;
   logic [2:0]          back_rank;
   chess_pkg::board_t   moved_board;
   chess_pkg::castle_t  moved_castle;

   function automatic logic can_land(chess_pkg::piece_t p, logic black);
      return p == `EMPTY_POSN || p[`BLACK_BIT] != black;
   endfunction

   // lowest direction set in m
   function automatic chess_pkg::dir_t first_dir(logic [3:0] m);
      chess_pkg::dir_t d;
      d = chess_pkg::DIR_DOWN;
      for (int i = 3; i >= 0; i--)
         if (m[i])
            d = chess_pkg::dir_t'(i);
      return d;
   endfunction

   assign mover_black = ~pos_white_to_move;
   assign back_rank = pos_white_to_move ? 3'd0 : 3'd7;
   assign src_piece = chess_pkg::sq_at(pos_board, sq[5:3], sq[2:0]);
   assign mover_slider = src_piece[`BLACK_BIT] == mover_black &&
                         (src_piece[2:0] == `PIECE_ROOK || src_piece[2:0] == `PIECE_QUEN);

   // first step of each ray from the source, checked up front
   for (genvar d = 0; d < 4; d++)
   begin : g_first
      logic [6:0] step;
      assign step = chess_pkg::ray_step(sq[5:3], sq[2:0], chess_pkg::dir_t'(d));
      assign first_rc[d] = step[5:0];
      assign first_ok[d] = step[6] &&
                           can_land(chess_pkg::sq_at(pos_board, step[5:3], step[2:0]), mover_black);
   end

   assign later_ok = first_ok & (4'b1110 << dir);
   assign nxt = chess_pkg::ray_step(cur_row, cur_col, dir);
   assign cur_piece = chess_pkg::sq_at(pos_board, cur_row, cur_col);
   assign cont_ok = cur_piece == `EMPTY_POSN && nxt[6] &&
                    can_land(chess_pkg::sq_at(pos_board, nxt[5:3], nxt[2:0]), mover_black);

   always_comb
   begin
      moved_board = pos_board;
      moved_board[{sq, 2'b00} +: `PIECE_BITS] = `EMPTY_POSN;
      moved_board[{cur_row, cur_col, 2'b00} +: `PIECE_BITS] = src_piece;
      moved_castle = pos_castle_mask;
      if (sq[5:3] == back_rank && sq[2:0] == 3'd7)
         moved_castle[pos_white_to_move ? `CASTLE_WHITE_SHORT : `CASTLE_BLACK_SHORT] = 1'b0;
      if (sq[5:3] == back_rank && sq[2:0] == 3'd0)
         moved_castle[pos_white_to_move ? `CASTLE_WHITE_LONG : `CASTLE_BLACK_LONG] = 1'b0;
   end

   always_ff @(posedge clk)
   begin
      wr_en <= 1'b0;
      gen_done <= 1'b0;
      if (reset)
         state <= S_IDLE;
      else
         case (state)
            S_IDLE:
               if (gen_start)
               begin
                  sq <= '0;
                  state <= S_SQUARE;
               end
            S_SQUARE:
               if (mover_slider && first_ok != 4'b0000)
               begin
                  dir <= first_dir(first_ok);
                  {cur_row, cur_col} <= first_rc[first_dir(first_ok)];
                  state <= S_STEP;
               end
               else
                  state <= S_NEXT;
            S_STEP:
            begin
               wr_en <= 1'b1;   // target already known legal
               state <= S_ADV;
            end
            S_ADV:
               if (cont_ok)
               begin
                  {cur_row, cur_col} <= nxt[5:0];
                  state <= S_STEP;
               end
               else if (later_ok != 4'b0000)
               begin
                  dir <= first_dir(later_ok);
                  {cur_row, cur_col} <= first_rc[first_dir(later_ok)];
                  state <= S_STEP;
               end
               else
                  state <= S_NEXT;
            S_NEXT:
               if (sq == 6'd63)
                  state <= S_DONE;
               else
               begin
                  sq <= sq + 6'd1;
                  state <= S_SQUARE;
               end
            S_DONE:
            begin
               gen_done <= 1'b1;
               state <= S_IDLE;
            end
            default: state <= S_IDLE;
         endcase
   end

   always_ff @(posedge clk)
      if (state == S_STEP)
      begin
         wr_board <= moved_board;
         wr_white_to_move <= ~pos_white_to_move;
         wr_castle_mask <= moved_castle;
         wr_en_passant_col <= `EN_PASSANT_INVALID;
      end

   a_wr_gap: assert property (@(posedge clk) disable iff (reset) wr_en |=> !wr_en);

endmodule

//--- flist.f
+incdir+design
design/chess_pkg.sv
design/check_detect.sv
design/slide_moves.sv
design/move_store.sv
design/move_gen_top.sv
sim/move_gen_checker.sv
sim/move_gen_tb.sv

//--- sim/move_gen_checker.sv
`include "chess_consts.svh"

module move_gen_checker
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   board_req,
   input  logic                   board_ack,
   input  chess_pkg::board_t      board_in,
   input  logic                   white_to_move_in,
   input  chess_pkg::castle_t     castle_mask_in,
   input  logic                   in_check,
   input  chess_pkg::move_addr_t  move_index,
   input  chess_pkg::move_addr_t  move_count,
   input  chess_pkg::board_t      board_out,
   input  logic                   white_to_move_out,
   input  chess_pkg::castle_t     castle_mask_out,
   input  chess_pkg::ep_col_t     en_passant_col_out,
   input  logic [159:0]           test_name,
   input  int                     exp_moves,
   input  logic                   exp_check,
   output int                     error_count,
   output int                     check_count
);

   // left, right, up, down
   localparam int DR [4] = '{0, 0, 1, -1};
   localparam int DC [4] = '{-1, 1, 0, 0};

   chess_pkg::board_t   exp_board [`MAX_POSITIONS];
   chess_pkg::castle_t  exp_castle [`MAX_POSITIONS];
   int                  model_count = 0;
   logic                model_check = 1'b0;
   logic                req_white = 1'b0;
   logic [63:0]         seen = '0;
   logic                req_q = 1'b0;
   logic                ack_q = 1'b0;
   logic                rd_valid = 1'b0;
   chess_pkg::move_addr_t rd_idx = '0;
   int                  missing;
   int                  errors = 0;
   int                  check_cnt = 0;

   assign error_count = errors;
   assign check_count = check_cnt;

   function automatic string name_str();
      string s;
      s = "";
      for (int i = 19; i >= 0; i--)
         if (test_name[i*8 +: 8] != 8'h00)
            s = $sformatf("%s%c", s, test_name[i*8 +: 8]);
      return s;
   endfunction

   function automatic chess_pkg::piece_t square(chess_pkg::board_t b, int r, int c);
      return b[(r * 8 + c) * 4 +: 4];
   endfunction

   task automatic expect_value(input string what, input logic [255:0] exp,
                               input logic [255:0] act);
      check_cnt++;
      if (exp !== act)
      begin
         errors++;
         $display("mismatch %s %s: expected %0h actual %0h", name_str(), what, exp, act);
      end
   endtask

   task automatic add_move(input int src, input int dst, input chess_pkg::piece_t p,
                           input logic black);
      chess_pkg::board_t nb;
      chess_pkg::castle_t nc;
      int home;
      home = black ? 7 : 0;
      nb = board_in;
      nb[src * 4 +: 4] = `EMPTY_POSN;
      nb[dst * 4 +: 4] = p;
      nc = castle_mask_in;
      if (src == home * 8 + 7)
         nc[black ? `CASTLE_BLACK_SHORT : `CASTLE_WHITE_SHORT] = 1'b0;
      if (src == home * 8)   // queen side corner
         nc[black ? `CASTLE_BLACK_LONG : `CASTLE_WHITE_LONG] = 1'b0;
      if (model_count < `MAX_POSITIONS)
      begin
         exp_board[model_count] = nb;
         exp_castle[model_count] = nc;
      end
      model_count++;
   endtask

   task automatic build_model();
      chess_pkg::piece_t p;
      chess_pkg::piece_t t;
      logic mover_black;
      logic blocked;
      int r;
      int c;
      mover_black = ~white_to_move_in;
      req_white = white_to_move_in;
      model_count = 0;
      model_check = 1'b0;
      for (int s = 0; s < 64; s++)
      begin
         p = square(board_in, s / 8, s % 8);
         if (p[2:0] == `PIECE_ROOK || p[2:0] == `PIECE_QUEN)
            for (int d = 0; d < 4; d++)
            begin
               r = s / 8 + DR[d];
               c = s % 8 + DC[d];
               blocked = 1'b0;
               while (!blocked && r >= 0 && r < 8 && c >= 0 && c < 8)
               begin
                  t = square(board_in, r, c);
                  if (p[`BLACK_BIT] != mover_black)
                  begin
                     blocked = t != `EMPTY_POSN;   // enemy ray only looks for our king
                     if (t == {mover_black, `PIECE_KING})
                        model_check = 1'b1;
                  end
                  else if (t != `EMPTY_POSN && t[`BLACK_BIT] == mover_black)
                     blocked = 1'b1;
                  else
                  begin
                     add_move(s, r * 8 + c, p, mover_black);
                     blocked = t != `EMPTY_POSN;   // capture ends the slide
                  end
                  r = r + DR[d];
                  c = c + DC[d];
               end
            end
      end
   endtask

   task automatic compare_read(input int i);
      seen[i] = 1'b1;
      expect_value($sformatf("move %0d board", i), exp_board[i], board_out);
      expect_value($sformatf("move %0d side", i), !req_white, white_to_move_out);
      expect_value($sformatf("move %0d castle", i), exp_castle[i], castle_mask_out);
      expect_value($sformatf("move %0d en passant", i), `EN_PASSANT_INVALID,
                   en_passant_col_out);
   endtask

   // outputs are settled by the falling edge
   always @(negedge clk)
      if (!reset)
      begin
         if (rd_valid)
            compare_read(rd_idx);
         if (board_req && !req_q)
         begin
            expect_value("count at request", 0, move_count);   // no stale moves
            build_model();
            seen = '0;
         end
         if (board_ack && !ack_q)
         begin
            expect_value("count vs model", model_count, move_count);
            expect_value("count vs table", exp_moves, move_count);
            expect_value("in_check vs model", model_check, in_check);
            expect_value("in_check vs table", exp_check, in_check);
         end
         if (ack_q && !board_ack)
         begin
            missing = 0;
            for (int i = 0; i < model_count && i < 64; i++)
               if (!seen[i])
                  missing++;
            check_cnt++;
            if (missing != 0)
            begin
               errors++;
               $display("%s: %0d stored moves were never read back", name_str(), missing);
            end
         end
         rd_valid = board_ack && board_req && move_index < model_count;
         rd_idx = move_index;
         req_q = board_req;
         ack_q = board_ack;
      end

endmodule

//--- sim/move_gen_tb.sv
`include "chess_consts.svh"

module move_gen_tb;

   localparam int NUM_TESTS = 6;
   localparam int CYCLE_LIMIT = NUM_TESTS * 300;   // slide bound plus read-back per entry

   localparam logic [3:0] W_PAWN = {1'b0, `PIECE_PAWN};
   localparam logic [3:0] W_ROOK = {1'b0, `PIECE_ROOK};
   localparam logic [3:0] W_QUEN = {1'b0, `PIECE_QUEN};
   localparam logic [3:0] W_KING = {1'b0, `PIECE_KING};
   localparam logic [3:0] B_PAWN = {1'b1, `PIECE_PAWN};
   localparam logic [3:0] B_KNIT = {1'b1, `PIECE_KNIT};
   localparam logic [3:0] B_ROOK = {1'b1, `PIECE_ROOK};
   localparam logic [3:0] B_QUEN = {1'b1, `PIECE_QUEN};
   localparam logic [3:0] B_KING = {1'b1, `PIECE_KING};

   typedef struct {
      logic [159:0]        name;
      chess_pkg::board_t   board;
      logic                white;
      chess_pkg::castle_t  castle;
      chess_pkg::ep_col_t  ep;
      int                  moves;
      logic                in_check;
   } entry_t;

   logic                   clk;
   logic                   reset;
   logic                   board_req;
   logic                   board_ack;
   chess_pkg::board_t      board_in;
   logic                   white_to_move_in;
   chess_pkg::castle_t     castle_mask_in;
   chess_pkg::ep_col_t     en_passant_col_in;
   logic                   in_check;
   chess_pkg::move_addr_t  move_index;
   chess_pkg::move_addr_t  move_count;
   chess_pkg::board_t      board_out;
   logic                   white_to_move_out;
   chess_pkg::castle_t     castle_mask_out;
   chess_pkg::ep_col_t     en_passant_col_out;
   logic [159:0]           test_name;
   int                     exp_moves;
   logic                   exp_check;
   int                     error_count;
   int                     check_count;
   int                     cycles = 0;
   entry_t                 tests [NUM_TESTS];

   move_gen_top dut
   (
      .clk(clk), .reset(reset), .board_req(board_req), .board_ack(board_ack),
      .board_in(board_in), .white_to_move_in(white_to_move_in),
      .castle_mask_in(castle_mask_in), .en_passant_col_in(en_passant_col_in),
      .in_check(in_check), .move_index(move_index), .move_count(move_count),
      .board_out(board_out), .white_to_move_out(white_to_move_out),
      .castle_mask_out(castle_mask_out), .en_passant_col_out(en_passant_col_out)
   );

   move_gen_checker u_checker
   (
      .clk(clk), .reset(reset), .board_req(board_req), .board_ack(board_ack),
      .board_in(board_in), .white_to_move_in(white_to_move_in),
      .castle_mask_in(castle_mask_in), .in_check(in_check), .move_index(move_index),
      .move_count(move_count), .board_out(board_out),
      .white_to_move_out(white_to_move_out), .castle_mask_out(castle_mask_out),
      .en_passant_col_out(en_passant_col_out), .test_name(test_name),
      .exp_moves(exp_moves), .exp_check(exp_check), .error_count(error_count),
      .check_count(check_count)
   );

   function automatic chess_pkg::board_t place(chess_pkg::board_t b, int r, int c,
                                               logic [3:0] p);
      b[(r * 8 + c) * 4 +: 4] = p;
      return b;
   endfunction

   task automatic set_entry(input int n, input logic [159:0] name, input chess_pkg::board_t b,
                            input logic white, input logic [3:0] castle, input logic [3:0] ep,
                            input int moves, input logic chk);
      tests[n] = '{name, b, white, castle, ep, moves, chk};
   endtask

   task automatic fill_table();
      chess_pkg::board_t b;
      b = place(place(place('0, 0, 0, W_ROOK), 0, 7, W_ROOK), 0, 4, W_KING);
      set_entry(0, "corner_rooks_w", b, 1'b1, 4'hf, 4'd3, 19, 1'b0);
      b = place(place(place('0, 7, 7, B_ROOK), 7, 4, B_KING), 3, 7, W_PAWN);
      b = place(place(b, 7, 0, W_ROOK), 0, 4, W_KING);
      set_entry(1, "black_rook_capture", b, 1'b0, 4'hf, 4'd8, 6, 1'b1);
      b = place(place(place('0, 0, 4, W_KING), 7, 4, B_ROOK), 3, 4, W_PAWN);
      b = place(b, 2, 2, W_QUEN);   // pawn shields the king
      set_entry(2, "blocked_line", b, 1'b1, 4'h0, 4'd8, 14, 1'b0);
      b = place(place('0, 4, 4, B_ROOK), 6, 1, B_QUEN);
      set_entry(3, "no_mover_sliders", b, 1'b1, 4'ha, 4'd5, 0, 1'b0);
      b = place(place(place('0, 6, 6, B_KING), 6, 0, W_QUEN), 7, 0, B_ROOK);
      b = place(b, 2, 5, B_QUEN);
      set_entry(4, "queen_check_black", b, 1'b0, 4'hf, 4'd8, 22, 1'b1);
      b = place(place(place('0, 3, 3, W_ROOK), 3, 2, W_PAWN), 3, 4, B_PAWN);
      b = place(place(b, 4, 3, W_PAWN), 2, 3, B_KNIT);
      set_entry(5, "crowded_rook", b, 1'b1, 4'h5, 4'd8, 2, 1'b0);
   endtask

   task automatic wait_ack(input logic level);
      @(posedge clk);
      while (board_ack !== level)
         @(posedge clk);
   endtask

   task automatic run_entry(input int n);
      @(posedge clk);
      board_in <= tests[n].board;
      white_to_move_in <= tests[n].white;
      castle_mask_in <= tests[n].castle;
      en_passant_col_in <= tests[n].ep;
      test_name <= tests[n].name;
      exp_moves <= tests[n].moves;
      exp_check <= tests[n].in_check;
      move_index <= '0;
      board_req <= 1'b1;
      wait_ack(1'b1);
      for (int i = 0; i < move_count; i++)
      begin
         @(posedge clk);
         move_index <= chess_pkg::move_addr_t'(i);
      end
      @(posedge clk);   // last read lands here
      board_req <= 1'b0;
      wait_ack(1'b0);
   endtask

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT)
      begin
         $display("timeout: handshake did not complete within %0d cycles", CYCLE_LIMIT);
         $display("*** FAILED ***");
         $finish;
      end
   end

   initial
   begin
      reset = 1'b1;
      board_req = 1'b0;
      board_in = '0;
      white_to_move_in = 1'b1;
      castle_mask_in = '0;
      en_passant_col_in = `EN_PASSANT_INVALID;
      move_index = '0;
      test_name = '0;
      exp_moves = 0;
      exp_check = 1'b0;
      fill_table();
      repeat (3) @(posedge clk);
      reset <= 1'b0;
      for (int n = 0; n < NUM_TESTS; n++)
         run_entry(n);
      repeat (2) @(posedge clk);
      $display("checks %0d, errors %0d", check_count, error_count);
      if (error_count == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule
